// File: files.f
tomasulo_pkg.sv
reg_status.sv
res_station.sv
exec_units.sv
issue_ctrl.sv
rs_core.sv
tb_rs_core.sv

// File: tb_rs_core.sv
module tb_rs_core;
  timeunit 1ns;
  timeprecision 1ps;
  import tomasulo_pkg::*;

  localparam int CYCLE_LIMIT = 2000; // about 60 issues of MUL_LATENCY + 8 cycles plus margin

  logic      clk = 1'b0;
  logic      reset = 1'b1;
  logic      req = 1'b0;
  op_t       op = OP_ADD;
  reg_addr_t dst = '0, src1 = '0, src2 = '0, rd_addr = '0;
  logic      has_imm = 1'b0;
  word_t     imm = '0;
  logic      ack;
  tag_t      rd_tag;
  word_t     rd_data;

  word_t  model [NUM_REGS]; // register values in issue order
  word_t  exp_data = '0;
  logic   chk_en = 1'b0;
  logic   must_accept, may_accept;
  string  test_name = "reset_state";
  integer seed = 32'h01942c22;
  int     errors = 0, errors_at_start = 0, pass_count = 0, fail_count = 0, cycles = 0;

  always #4 clk = ~clk;

  rs_core DUT (
    .clk, .reset, .req, .op, .dst, .src1, .src2, .has_imm, .imm, .ack,
    .rd_addr, .rd_tag, .rd_data
  );

  // acceptance bounds from bank occupancy
  always_comb begin
    case (op)
      OP_ADD:  must_accept = DUT.add_has_free;
      OP_MUL:  must_accept = DUT.mul_has_free;
      OP_MV:   must_accept = has_imm || DUT.add_has_free;
      default: must_accept = DUT.add_empty && DUT.mul_empty;
    endcase
    may_accept = must_accept || op == OP_MV; // a ready source needs no station
  end

  function automatic void note_error(input string msg);
    errors++;
    $display("Error in %s: %s", test_name, msg);
  endfunction

  ack_after_reset: assert property (@(posedge clk) $fell(reset) |-> !ack)
    else note_error("ack was high coming out of reset");
  accept_when_ready: assert property (@(posedge clk) disable iff (reset)
    req && !ack && must_accept |=> ack)
    else note_error("acceptable instruction was not acknowledged");
  stall_when_busy: assert property (@(posedge clk) disable iff (reset)
    req && !ack && !may_accept |=> !ack)
    else note_error("ack rose while the station bank was full or busy");
  rise_with_req: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
    else note_error("ack rose while req was low");
  fall_after_req: assert property (@(posedge clk) disable iff (reset)
    $fell(ack) |-> $past(!req))
    else note_error("ack fell before req was dropped");
  reg_tag_clear: assert property (@(posedge clk) chk_en |-> rd_tag == TAG_NONE)
    else begin
      errors++;
      $display("Fail %s r%0d tag expected %0d actual %0d", test_name,
               $sampled(rd_addr), TAG_NONE, $sampled(rd_tag));
    end
  reg_value: assert property (@(posedge clk) chk_en |-> rd_data == exp_data)
    else begin
      errors++;
      $display("Fail %s r%0d expected %h actual %h", test_name,
               $sampled(rd_addr), $sampled(exp_data), $sampled(rd_data));
    end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, the run went past %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  // full four-phase handshake starting just after a rising edge
  task automatic issue(input op_t o, input int d, input int s1, input int s2,
                       input logic hi, input word_t im);
    word_t b;
    b = hi ? im : model[s2];
    req     <= 1'b1;
    op      <= o;
    dst     <= reg_addr_t'(d);
    src1    <= reg_addr_t'(s1);
    src2    <= reg_addr_t'(s2);
    has_imm <= hi;
    imm     <= im;
    do @(posedge clk); while (!ack);
    req <= 1'b0;
    case (o)
      OP_ADD:  model[d] = model[s1] + b;
      OP_MUL:  model[d] = model[s1] * b; // low word
      OP_MV:   model[d] = hi ? im : model[s1];
      default: ;
    endcase
    do @(posedge clk); while (ack);
  endtask

  task automatic random_instr(input bit use_mul);
    int    kind;
    int    d;
    int    s1;
    int    s2;
    word_t im;
    kind = {$random(seed)} % (use_mul ? 6 : 4);
    d    = {$random(seed)} % NUM_REGS;
    s1   = {$random(seed)} % NUM_REGS;
    s2   = {$random(seed)} % NUM_REGS;
    im   = $random(seed);
    case (kind)
      0:       issue(OP_ADD, d, s1, s2, 1'b0, im);
      1:       issue(OP_ADD, d, s1, s2, 1'b1, im);
      2:       issue(OP_MV, d, s1, s2, 1'b0, im);
      3:       issue(OP_MV, d, s1, s2, 1'b1, im);
      4:       issue(OP_MUL, d, s1, s2, 1'b0, im);
      default: issue(OP_MUL, d, s1, s2, 1'b1, im & 32'hff);
    endcase
  endtask

  task automatic check_reg(input int r);
    rd_addr  <= reg_addr_t'(r);
    exp_data <= model[r];
    chk_en   <= 1'b1;
    @(posedge clk);
    chk_en <= 1'b0;
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test;
    @(posedge clk); // lets the last sampled check report
    if (errors == errors_at_start) begin
      pass_count++;
      $display("test %s passed", test_name);
    end else begin
      fail_count++;
      $display("test %s failed with %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  initial begin
    for (int r = 0; r < NUM_REGS; r++)
      model[r] = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    begin_test("reset_state");
    for (int r = 0; r < NUM_REGS; r++)
      check_reg(r);
    end_test();

    begin_test("imm_move");
    issue(OP_MUL, 1, 1, 2, 1'b1, 32'd3); // mul bank busy meanwhile
    issue(OP_MV, 5, 0, 0, 1'b1, $random(seed));
    check_reg(5);
    end_test();

    begin_test("add_move_chains");
    for (int r = 0; r < NUM_REGS; r++)
      issue(OP_MV, r, 0, 0, 1'b1, $random(seed));
    repeat (16) random_instr(1'b0);
    issue(OP_HALT, 0, 0, 0, 1'b0, '0);
    for (int r = 0; r < NUM_REGS; r++)
      check_reg(r);
    end_test();

    begin_test("mixed_chains");
    repeat (20) random_instr(1'b1);
    for (int k = 0; k < 4; k++)
      issue(OP_MUL, 4 + k, k, k + 1, 1'b0, '0);
    issue(OP_HALT, 0, 0, 0, 1'b0, '0);
    for (int r = 0; r < NUM_REGS; r++)
      check_reg(r);
    end_test();

    begin_test("mul_backpressure");
    issue(OP_MUL, 2, 3, 4, 1'b0, '0);
    for (int k = 0; k < 5; k++)
      issue(OP_MUL, 2, 2, 1 + k, 1'b0, '0); // r2 pending at each issue
    issue(OP_HALT, 0, 0, 0, 1'b0, '0);
    for (int r = 0; r < NUM_REGS; r++)
      check_reg(r);
    end_test();

    begin_test("halt_drain");
    issue(OP_MUL, 6, 2, 2, 1'b0, '0);
    issue(OP_ADD, 0, 6, 6, 1'b0, '0);
    issue(OP_MUL, 7, 0, 6, 1'b0, '0); // still in the pipeline when halt arrives
    issue(OP_HALT, 0, 0, 0, 1'b0, '0);
    for (int r = 0; r < NUM_REGS; r++)
      check_reg(r);
    end_test();

    $display("tests passed %0d failed %0d, errors %0d", pass_count, fail_count, errors);
    if (fail_count == 0 && errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: rs_core.sv
module rs_core (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req,
  input  tomasulo_pkg::op_t       op,
  input  tomasulo_pkg::reg_addr_t dst,
  input  tomasulo_pkg::reg_addr_t src1,
  input  tomasulo_pkg::reg_addr_t src2,
  input  logic                    has_imm,
  input  tomasulo_pkg::word_t     imm,
  output logic                    ack,
  input  tomasulo_pkg::reg_addr_t rd_addr,
  output tomasulo_pkg::tag_t      rd_tag,
  output tomasulo_pkg::word_t     rd_data
);
  import tomasulo_pkg::*;

  word_t     op1_data, op2_data, b_data, imm_data;
  tag_t      op1_tag, op2_tag, b_tag, rename_tag;
  logic      rename_en, imm_wr_en;
  reg_addr_t rename_reg, imm_reg;

  logic  add_alloc, add_has_free, add_empty, add_grant;
  logic  mul_alloc, mul_has_free, mul_empty;
  tag_t  add_free_tag, mul_free_tag;

  logic  add_disp_valid, mul_disp_valid;
  tag_t  add_disp_tag, mul_disp_tag;
  word_t add_disp_a, add_disp_b, mul_disp_a, mul_disp_b;

  logic  cdb_valid;
  tag_t  cdb_tag;
  word_t cdb_data;

  reg_status status (
    .clk, .reset, .src1, .src2,
    .op1_data, .op1_tag, .op2_data, .op2_tag,
    .rename_en, .rename_reg, .rename_tag,
    .imm_wr_en, .imm_reg, .imm_data,
    .cdb_valid, .cdb_tag, .cdb_data,
    .rd_addr, .rd_tag, .rd_data
  );

  res_station #(.NUM_ENTRIES(NUM_ADD_RS), .TAG_BASE(ADD_TAG_BASE)) add_rs (
    .clk, .reset, .alloc(add_alloc),
    .a_data(op1_data), .a_tag(op1_tag), .b_data, .b_tag,
    .has_free(add_has_free), .free_tag(add_free_tag), .empty(add_empty),
    .grant(add_grant),
    .disp_valid(add_disp_valid), .disp_tag(add_disp_tag),
    .disp_a(add_disp_a), .disp_b(add_disp_b),
    .cdb_valid, .cdb_tag, .cdb_data
  );

  res_station #(.NUM_ENTRIES(NUM_MUL_RS), .TAG_BASE(MUL_TAG_BASE)) mul_rs (
    .clk, .reset, .alloc(mul_alloc),
    .a_data(op1_data), .a_tag(op1_tag), .b_data, .b_tag,
    .has_free(mul_has_free), .free_tag(mul_free_tag), .empty(mul_empty),
    .grant(1'b1), // pipeline takes one per cycle
    .disp_valid(mul_disp_valid), .disp_tag(mul_disp_tag),
    .disp_a(mul_disp_a), .disp_b(mul_disp_b),
    .cdb_valid, .cdb_tag, .cdb_data
  );

  exec_units units (
    .clk, .reset,
    .add_valid(add_disp_valid), .add_tag(add_disp_tag),
    .add_a(add_disp_a), .add_b(add_disp_b),
    .mul_valid(mul_disp_valid), .mul_tag(mul_disp_tag),
    .mul_a(mul_disp_a), .mul_b(mul_disp_b),
    .add_grant, .cdb_valid, .cdb_tag, .cdb_data
  );

  issue_ctrl issue (
    .clk, .reset, .req, .op, .dst, .has_imm, .imm, .ack,
    .op1_data, .op1_tag, .op2_tag, .op2_data,
    .add_has_free, .add_free_tag, .add_empty,
    .mul_has_free, .mul_free_tag, .mul_empty,
    .add_alloc, .mul_alloc, .b_data, .b_tag,
    .rename_en, .rename_reg, .rename_tag,
    .imm_wr_en, .imm_reg, .imm_data
  );

endmodule

// File: issue_ctrl.sv
module issue_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req,
  input  tomasulo_pkg::op_t       op,
  input  tomasulo_pkg::reg_addr_t dst,
  input  logic                    has_imm,
  input  tomasulo_pkg::word_t     imm,
  output logic                    ack,
  input  tomasulo_pkg::word_t     op1_data,
  input  tomasulo_pkg::tag_t      op1_tag,
  input  tomasulo_pkg::tag_t      op2_tag,
  input  tomasulo_pkg::word_t     op2_data,
  input  logic                    add_has_free,
  input  tomasulo_pkg::tag_t      add_free_tag,
  input  logic                    add_empty,
  input  logic                    mul_has_free,
  input  tomasulo_pkg::tag_t      mul_free_tag,
  input  logic                    mul_empty,
  output logic                    add_alloc,
  output logic                    mul_alloc,
  output tomasulo_pkg::word_t     b_data,
  output tomasulo_pkg::tag_t      b_tag,
  output logic                    rename_en,
  output tomasulo_pkg::reg_addr_t rename_reg,
  output tomasulo_pkg::tag_t      rename_tag,
  output logic                    imm_wr_en,
  output tomasulo_pkg::reg_addr_t imm_reg,
  output tomasulo_pkg::word_t     imm_data
);
  import tomasulo_pkg::*;

  issue_state_t state;
  logic         accept;
  logic         fire;
  logic         mv_direct;

  // move with its value already known skips the add bank
  assign mv_direct = (op == OP_MV) && (has_imm || op1_tag == TAG_NONE);

  always_comb begin
    case (op)
      OP_ADD:  accept = add_has_free;
      OP_MUL:  accept = mul_has_free;
      OP_MV:   accept = mv_direct || add_has_free;
      OP_HALT: accept = add_empty && mul_empty; // drain before ack
      default: accept = 1'b0;
    endcase
  end

  assign fire = (state == ISSUE_IDLE) && req && accept;

  assign add_alloc = fire && (op == OP_ADD || (op == OP_MV && !mv_direct));
  assign mul_alloc = fire && (op == OP_MUL);

  // second operand
  always_comb begin
    if (op == OP_MV) begin
      b_data = '0; // source plus zero
      b_tag  = TAG_NONE;
    end else if (has_imm) begin
      b_data = imm;
      b_tag  = TAG_NONE;
    end else begin
      b_data = op2_data;
      b_tag  = op2_tag;
    end
  end

  assign rename_en  = add_alloc || mul_alloc;
  assign rename_reg = dst;
  assign rename_tag = mul_alloc ? mul_free_tag : add_free_tag;

  assign imm_wr_en = fire && mv_direct;
  assign imm_reg   = dst;
  assign imm_data  = has_imm ? imm : op1_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ISSUE_IDLE;
    end else begin
      case (state)
        ISSUE_IDLE:    if (fire) state <= ISSUE_RELEASE;
        ISSUE_RELEASE: if (!req) state <= ISSUE_IDLE;
        default:       state <= ISSUE_IDLE;
      endcase
    end
  end

  assign ack = (state == ISSUE_RELEASE);

endmodule

// File: exec_units.sv
module exec_units (
  input  logic                clk,
  input  logic                reset,
  input  logic                add_valid,
  input  tomasulo_pkg::tag_t  add_tag,
  input  tomasulo_pkg::word_t add_a,
  input  tomasulo_pkg::word_t add_b,
  input  logic                mul_valid,
  input  tomasulo_pkg::tag_t  mul_tag,
  input  tomasulo_pkg::word_t mul_a,
  input  tomasulo_pkg::word_t mul_b,
  output logic                add_grant,
  output logic                cdb_valid,
  output tomasulo_pkg::tag_t  cdb_tag,
  output tomasulo_pkg::word_t cdb_data
);
  import tomasulo_pkg::*;

  logic  add_res_v;
  tag_t  add_res_tag;
  word_t add_res;

  logic [MUL_LATENCY-1:0] mul_v; // bit 0 is the newest stage
  tag_t  mul_t [MUL_LATENCY];
  word_t mul_d [MUL_LATENCY];

  always_ff @(posedge clk) begin
    if (reset) begin
      add_res_v <= 1'b0;
      mul_v     <= '0;
    end else begin
      add_res_v <= add_valid;
      mul_v     <= {mul_v[MUL_LATENCY-2:0], mul_valid}; // always advances
    end
  end

  always_ff @(posedge clk) begin
    if (add_valid) begin
      add_res     <= add_a + add_b;
      add_res_tag <= add_tag;
    end
    mul_t[0] <= mul_tag;
    mul_d[0] <= mul_a * mul_b; // low word only
    for (int s = 1; s < MUL_LATENCY; s++) begin
      mul_t[s] <= mul_t[s-1];
      mul_d[s] <= mul_d[s-1];
    end
  end

  // a multiply leaves next cycle, hold adds back
  assign add_grant = !mul_v[MUL_LATENCY-2];

  // multiplier output has the bus first
  always_comb begin
    if (mul_v[MUL_LATENCY-1]) begin
      cdb_valid = 1'b1;
      cdb_tag   = mul_t[MUL_LATENCY-1];
      cdb_data  = mul_d[MUL_LATENCY-1];
    end else begin
      cdb_valid = add_res_v;
      cdb_tag   = add_res_tag;
      cdb_data  = add_res;
    end
  end

endmodule

// File: res_station.sv
module res_station #(
  parameter int                 NUM_ENTRIES = tomasulo_pkg::NUM_ADD_RS,
  parameter tomasulo_pkg::tag_t TAG_BASE    = tomasulo_pkg::ADD_TAG_BASE
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                alloc,
  input  tomasulo_pkg::word_t a_data,
  input  tomasulo_pkg::tag_t  a_tag,
  input  tomasulo_pkg::word_t b_data,
  input  tomasulo_pkg::tag_t  b_tag,
  output logic                has_free,
  output tomasulo_pkg::tag_t  free_tag,
  output logic                empty,
  input  logic                grant,
  output logic                disp_valid,
  output tomasulo_pkg::tag_t  disp_tag,
  output tomasulo_pkg::word_t disp_a,
  output tomasulo_pkg::word_t disp_b,
  input  logic                cdb_valid,
  input  tomasulo_pkg::tag_t  cdb_tag,
  input  tomasulo_pkg::word_t cdb_data
);
  import tomasulo_pkg::*;

  localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

  logic [NUM_ENTRIES-1:0] busy;
  logic [NUM_ENTRIES-1:0] issued; // sent to the unit, result not yet back
  word_t a_val [NUM_ENTRIES];
  tag_t  a_src [NUM_ENTRIES];
  word_t b_val [NUM_ENTRIES];
  tag_t  b_src [NUM_ENTRIES];

  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] disp_idx;
  logic             ready_any;

  // lowest free entry
  always_comb begin
    has_free = 1'b0;
    free_idx = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        has_free = 1'b1;
        free_idx = IDX_W'(i);
      end
    end
  end

  assign free_tag = has_free ? tag_t'(TAG_BASE + free_idx) : TAG_NONE;
  assign empty    = ~|busy;

  // lowest entry with both operands in hand
  always_comb begin
    ready_any = 1'b0;
    disp_idx  = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (busy[i] && !issued[i] && a_src[i] == TAG_NONE && b_src[i] == TAG_NONE) begin
        ready_any = 1'b1;
        disp_idx  = IDX_W'(i);
      end
    end
  end

  assign disp_valid = ready_any && grant;
  assign disp_tag   = tag_t'(TAG_BASE + disp_idx);
  assign disp_a     = a_val[disp_idx];
  assign disp_b     = b_val[disp_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy   <= '0;
      issued <= '0;
    end else begin
      // entry stays held until its own tag is broadcast
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        if (busy[i] && cdb_valid && cdb_tag == tag_t'(TAG_BASE + i)) begin
          busy[i]   <= 1'b0;
          issued[i] <= 1'b0;
        end
      end
      if (disp_valid)
        issued[disp_idx] <= 1'b1;
      if (alloc && has_free) begin
        busy[free_idx]   <= 1'b1;
        issued[free_idx] <= 1'b0;
      end
    end
  end

  // operand capture from the bus, then the new entry
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (cdb_valid && a_src[i] != TAG_NONE && a_src[i] == cdb_tag) begin
        a_val[i] <= cdb_data;
        a_src[i] <= TAG_NONE;
      end
      if (cdb_valid && b_src[i] != TAG_NONE && b_src[i] == cdb_tag) begin
        b_val[i] <= cdb_data;
        b_src[i] <= TAG_NONE;
      end
    end
    if (alloc && has_free) begin
      a_val[free_idx] <= a_data; // already forwarded by the status table
      a_src[free_idx] <= a_tag;
      b_val[free_idx] <= b_data;
      b_src[free_idx] <= b_tag;
    end
  end

endmodule

// File: reg_status.sv
module reg_status (
  input  logic                    clk,
  input  logic                    reset,
  input  tomasulo_pkg::reg_addr_t src1,
  input  tomasulo_pkg::reg_addr_t src2,
  output tomasulo_pkg::word_t     op1_data,
  output tomasulo_pkg::tag_t      op1_tag,
  output tomasulo_pkg::word_t     op2_data,
  output tomasulo_pkg::tag_t      op2_tag,
  input  logic                    rename_en,
  input  tomasulo_pkg::reg_addr_t rename_reg,
  input  tomasulo_pkg::tag_t      rename_tag,
  input  logic                    imm_wr_en,
  input  tomasulo_pkg::reg_addr_t imm_reg,
  input  tomasulo_pkg::word_t     imm_data,
  input  logic                    cdb_valid,
  input  tomasulo_pkg::tag_t      cdb_tag,
  input  tomasulo_pkg::word_t     cdb_data,
  input  tomasulo_pkg::reg_addr_t rd_addr,
  output tomasulo_pkg::tag_t      rd_tag,
  output tomasulo_pkg::word_t     rd_data
);
  import tomasulo_pkg::*;

  word_t rf   [NUM_REGS];
  tag_t  rtag [NUM_REGS]; // producer of the pending value

  // operand lookup, a result on the bus this cycle is taken directly
  always_comb begin
    op1_data = rf[src1];
    op1_tag  = rtag[src1];
    if (cdb_valid && rtag[src1] != TAG_NONE && rtag[src1] == cdb_tag) begin
      op1_data = cdb_data;
      op1_tag  = TAG_NONE;
    end
    op2_data = rf[src2];
    op2_tag  = rtag[src2];
    if (cdb_valid && rtag[src2] != TAG_NONE && rtag[src2] == cdb_tag) begin
      op2_data = cdb_data;
      op2_tag  = TAG_NONE;
    end
  end

  assign rd_tag  = rtag[rd_addr];
  assign rd_data = rf[rd_addr];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        rf[r]   <= '0;
        rtag[r] <= TAG_NONE;
      end
    end else begin
      // retire every register waiting on the broadcast tag
      for (int r = 0; r < NUM_REGS; r++) begin
        if (cdb_valid && rtag[r] != TAG_NONE && rtag[r] == cdb_tag) begin
          rf[r]   <= cdb_data;
          rtag[r] <= TAG_NONE;
        end
      end
      if (rename_en)
        rtag[rename_reg] <= rename_tag; // newer producer overrides the bus write
      if (imm_wr_en) begin
        rf[imm_reg]   <= imm_data;
        rtag[imm_reg] <= TAG_NONE;
      end
    end
  end

endmodule

// File: tomasulo_pkg.sv
package tomasulo_pkg;

  // datapath and storage sizes
  localparam int WORD_W      = 32;
  localparam int NUM_REGS    = 8;
  localparam int REG_AW      = 3;
  localparam int NUM_ADD_RS  = 4;
  localparam int NUM_MUL_RS  = 4;
  localparam int TAG_W       = 4;
  localparam int MUL_LATENCY = 3; // multiplier pipeline depth

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [REG_AW-1:0] reg_addr_t;
  typedef logic [TAG_W-1:0]  tag_t;

  // producer tags
  // 0 means the register holds its own value, 1..4 add stations, 5..8 mul stations
  localparam tag_t TAG_NONE     = 4'd0;
  localparam tag_t ADD_TAG_BASE = 4'd1;
  localparam tag_t MUL_TAG_BASE = 4'd5;

  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_MUL  = 2'd1,
    OP_MV   = 2'd2,
    OP_HALT = 2'd3
  } op_t;

  typedef enum logic {
    ISSUE_IDLE    = 1'b0,
    ISSUE_RELEASE = 1'b1 // waiting for req to drop
  } issue_state_t;

endpackage
